// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

VERILATOR  ?= verilator
TOP        ?= tb_fetch
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the output is kept in a shell variable and searched for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/branch_predictor.sv ====
// direct-mapped branch target buffer with 2-bit saturating counters, trained from execute

`timescale 1ns/1ps

module branch_predictor #(
	parameter int bp_entries = 16  // power of two
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic [fetch_pkg::xlen-1:0] pc,            // fetch pc, looked up combinationally
	input  logic                     ex_branch,     // resolved branch in execute
	input  logic [fetch_pkg::xlen-1:0] ex_pc,
	input  logic                     ex_taken,
	input  logic [fetch_pkg::xlen-1:0] ex_target_pc,
	output logic                     predict_taken,
	output logic [fetch_pkg::xlen-1:0] predict_target
);

	import fetch_pkg::*;

	localparam int idx_w = $clog2(bp_entries);
	localparam int tag_w = xlen - idx_w - 2;  // word aligned, low two bits dropped

	//////////////////////////////////////////////////
	// entry storage
	//////////////////////////////////////////////////

	logic [bp_entries-1:0] entry_valid;
	logic [tag_w-1:0]      entry_tag     [bp_entries];
	logic [xlen-1:0]       entry_target  [bp_entries];
	logic [1:0]            entry_counter [bp_entries];  // >= 2 means taken

	logic [idx_w-1:0] rd_idx;
	logic [tag_w-1:0] rd_tag;
	logic [idx_w-1:0] wr_idx;
	logic [tag_w-1:0] wr_tag;
	logic             rd_hit;
	logic             wr_hit;

	assign rd_idx = pc[idx_w+1:2];     // word index bits
	assign rd_tag = pc[xlen-1:idx_w+2];
	assign wr_idx = ex_pc[idx_w+1:2];
	assign wr_tag = ex_pc[xlen-1:idx_w+2];

	assign rd_hit = entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
	assign wr_hit = entry_valid[wr_idx] && (entry_tag[wr_idx] == wr_tag);

	// lookup
	assign predict_taken  = rd_hit && entry_counter[rd_idx][1];
	assign predict_target = entry_target[rd_idx];

	//////////////////////////////////////////////////
	// training
	//////////////////////////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			entry_valid <= '0;  // all entries invalid
		end else if (ex_branch) begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	// entry payload: tag, target and direction counter
	always_ff @(posedge clock) begin
		if (ex_branch) begin
			entry_tag[wr_idx] <= wr_tag;
			if (!wr_hit) begin
				// new or replaced entry starts weak in the resolved direction
				entry_counter[wr_idx] <= ex_taken ? 2'b10 : 2'b01;
				entry_target[wr_idx]  <= ex_target_pc;
			end else begin
				if (ex_taken && entry_counter[wr_idx] != 2'b11)
					entry_counter[wr_idx] <= entry_counter[wr_idx] + 2'b01;  // saturate up
				else if (!ex_taken && entry_counter[wr_idx] != 2'b00)
					entry_counter[wr_idx] <= entry_counter[wr_idx] - 2'b01;  // saturate down
				if (ex_taken)
					entry_target[wr_idx] <= ex_target_pc;  // keep latest taken target
			end
		end
	end

endmodule

// ==== rtl/fetch_drain.sv ====
// head pointer, head slot selection and decode-side valid/ready handshake

`timescale 1ns/1ps

module fetch_drain #(
	parameter int queue_depth = 4
) (
	input  logic                                              clock,
	input  logic                                              reset,
	input  logic                                              flush,
	input  logic                                              decode_ready,
	input  logic [queue_depth-1:0]                            slot_ready_vec,
	input  logic [queue_depth-1:0][fetch_pkg::xlen-1:0]       slot_pc,
	input  logic [queue_depth-1:0][fetch_pkg::inst_width-1:0] slot_inst,
	input  logic [queue_depth-1:0]                            slot_predict_taken,
	input  logic [queue_depth-1:0][fetch_pkg::xlen-1:0]       slot_predict_target,
	output logic                                              if_valid,
	output logic [fetch_pkg::xlen-1:0]                        if_pc,
	output logic [fetch_pkg::xlen-1:0]                        if_npc,
	output logic [fetch_pkg::inst_width-1:0]                  if_inst,
	output logic                                              if_predict_taken,
	output logic [fetch_pkg::xlen-1:0]                        if_predict_target,
	output logic                                              pop,
	output logic [queue_depth-1:0]                            release_vec  // one-hot
);

	import fetch_pkg::*;

	localparam int idx_w = $clog2(queue_depth);

	logic [idx_w-1:0] head;  // oldest in-flight fetch

	//////////////////////////////////////////////////
	// head mux onto decode
	//////////////////////////////////////////////////

	assign if_valid          = slot_ready_vec[head];  // head data arrived
	assign if_pc             = slot_pc[head];
	assign if_npc            = slot_pc[head] + xlen'(4);
	assign if_inst           = slot_inst[head];
	assign if_predict_taken  = slot_predict_taken[head];
	assign if_predict_target = slot_predict_target[head];

	assign pop         = if_valid && decode_ready;  // transfer on this edge
	assign release_vec = pop ? ({{(queue_depth-1){1'b0}}, 1'b1} << head) : '0;

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			head <= '0;
		else if (flush)
			head <= '0;
		else if (pop)
			head <= head + idx_w'(1);  // wraps with the ring
	end

	// stalled head holds until decode takes it
	a_stall_stable: assert property (@(posedge clock) disable iff (reset)
		if_valid && !decode_ready && !flush |=> if_valid && $stable(if_pc) && $stable(if_inst));

endmodule

// ==== rtl/fetch_pc_gen.sv ====
// pc register, next-pc choice, memory load request, tail pointer and queue occupancy

`timescale 1ns/1ps

module fetch_pc_gen #(
	parameter int queue_depth = 4  // power of two
) (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              predict_taken,
	input  logic [fetch_pkg::xlen-1:0]        predict_target,
	input  logic                              branch_misprediction,  // flush from execute
	input  logic [fetch_pkg::xlen-1:0]        ex_target_pc,
	input  logic [fetch_pkg::tag_width-1:0]   mem_response,          // nonzero = accepted
	input  logic                              pop,                   // head slot handed to decode
	output logic [fetch_pkg::xlen-1:0]        pc,
	output fetch_pkg::bus_command_e           mem_command,
	output logic [fetch_pkg::xlen-1:0]        mem_addr,
	output logic                              alloc,
	output logic [$clog2(queue_depth)-1:0]    tail_index,
	output logic [fetch_pkg::xlen-1:0]        alloc_pc,
	output logic [fetch_pkg::tag_width-1:0]   alloc_tag,
	output logic                              alloc_predict_taken,
	output logic [fetch_pkg::xlen-1:0]        alloc_predict_target
);

	import fetch_pkg::*;

	localparam int idx_w = $clog2(queue_depth);
	localparam int cnt_w = idx_w + 1;  // counts 0 .. queue_depth

	logic [idx_w-1:0] tail;
	logic [cnt_w-1:0] occupancy;
	logic             fetch_enable;  // low for the reset cycle
	logic             queue_full;
	logic             issue;
	logic [xlen-1:0]  next_pc;

	//////////////////////////////////////////////////
	// request side
	//////////////////////////////////////////////////

	assign queue_full = (occupancy == cnt_w'(queue_depth));
	// no new load in a flush cycle, its slot would be wiped anyway
	assign issue       = fetch_enable && !queue_full && !branch_misprediction;
	assign mem_command = issue ? bus_load : bus_none;
	assign mem_addr    = {pc[xlen-1:3], 3'b000};  // 64-bit aligned beat

	assign alloc                = issue && (mem_response != tag_none);
	assign tail_index           = tail;
	assign alloc_pc             = pc;
	assign alloc_tag            = mem_response;
	assign alloc_predict_taken  = predict_taken;
	assign alloc_predict_target = predict_target;

	// predicted target or fall-through
	assign next_pc = predict_taken ? predict_target : pc + xlen'(4);

	//////////////////////////////////////////////////
	// pc, tail, occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc           <= '0;
			tail         <= '0;
			occupancy    <= '0;
			fetch_enable <= 1'b0;
		end else begin
			fetch_enable <= 1'b1;
			if (branch_misprediction) begin
				pc        <= ex_target_pc;  // redirect wins over everything
				tail      <= '0;
				occupancy <= '0;
			end else begin
				if (alloc) begin
					pc   <= next_pc;  // pc only moves on an accepted load
					tail <= tail + idx_w'(1);
				end
				occupancy <= occupancy + cnt_w'(alloc) - cnt_w'(pop);
			end
		end
	end

	// queue bookkeeping stays in range across pc_gen and drain
	a_occupancy_bound: assert property (@(posedge clock) disable iff (reset)
		occupancy <= cnt_w'(queue_depth));
	a_pop_nonempty: assert property (@(posedge clock) disable iff (reset)
		pop |-> occupancy != '0);

endmodule

// ==== rtl/fetch_pkg.sv ====
// fetch front end package: widths, memory bus command enum, fetch slot state enum

package fetch_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int xlen       = 32;  // address and pc width
	localparam int tag_width  = 4;   // memory response tag, 0 = none
	localparam int data_width = 64;  // memory returns two instructions per beat
	localparam int inst_width = 32;  // one instruction

	//////////////////////////////////////////////////
	// memory bus command
	//////////////////////////////////////////////////

	// the fetch side only ever loads, store is here so the
	// encoding matches the shared memory bus
	typedef enum logic [1:0] {
		bus_none  = 2'h0,  // idle
		bus_load  = 2'h1,  // fetch request
		bus_store = 2'h2   // data side only
	} bus_command_e;

	//////////////////////////////////////////////////
	// fetch slot state
	//////////////////////////////////////////////////

	// lifetime of one queue entry:
	// empty -> wait on accepted load -> ready on tag match -> empty on pop
	typedef enum logic [1:0] {
		slot_empty = 2'h0,  // free for allocation
		slot_wait  = 2'h1,  // load accepted, data pending
		slot_ready = 2'h2   // instruction held for decode
	} slot_state_e;

	// tag value that the memory never hands out
	localparam logic [tag_width-1:0] tag_none = '0;

	// word select inside the 64-bit beat
	localparam int word_sel_bit = 2;

endpackage

// ==== rtl/fetch_slot.sv ====
// one fetch queue entry: records a tag, waits for its data and holds the fetched word

`timescale 1ns/1ps

module fetch_slot (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             flush,
	input  logic                             alloc,                 // this slot gets the new load
	input  logic [fetch_pkg::xlen-1:0]       alloc_pc,
	input  logic [fetch_pkg::tag_width-1:0]  alloc_tag,
	input  logic                             alloc_predict_taken,
	input  logic [fetch_pkg::xlen-1:0]       alloc_predict_target,
	input  logic [fetch_pkg::tag_width-1:0]  mem_tag,               // broadcast from memory
	input  logic [fetch_pkg::data_width-1:0] mem_data,
	input  logic                             slot_release,          // popped by drain
	output logic                             ready,
	output logic [fetch_pkg::xlen-1:0]       slot_pc,
	output logic [fetch_pkg::inst_width-1:0] slot_inst,
	output logic                             slot_predict_taken,
	output logic [fetch_pkg::xlen-1:0]       slot_predict_target
);

	import fetch_pkg::*;

	slot_state_e           state;
	logic [tag_width-1:0]  slot_tag;
	logic                  tag_match;

	// tag 0 never matches, the memory uses it for no data
	assign tag_match = (mem_tag != tag_none) && (mem_tag == slot_tag);
	assign ready     = (state == slot_ready);

	//////////////////////////////////////////////////
	// state
	//////////////////////////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= slot_empty;
		end else if (flush) begin
			state <= slot_empty;  // late data for this tag falls on the floor
		end else begin
			case (state)
				slot_empty: if (alloc)        state <= slot_wait;
				slot_wait:  if (tag_match)    state <= slot_ready;
				slot_ready: if (slot_release) state <= slot_empty;
				default:                      state <= slot_empty;
			endcase
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (alloc && state == slot_empty) begin
			slot_pc             <= alloc_pc;
			slot_tag            <= alloc_tag;
			slot_predict_taken  <= alloc_predict_taken;
			slot_predict_target <= alloc_predict_target;
		end
		if (state == slot_wait && tag_match)  // pick our half of the beat
			slot_inst <= slot_pc[word_sel_bit] ? mem_data[63:32] : mem_data[31:0];
	end

	a_alloc_empty: assert property (@(posedge clock) disable iff (reset)
		alloc |-> state == slot_empty);
	a_release_ready: assert property (@(posedge clock) disable iff (reset)
		slot_release |-> state == slot_ready);

endmodule

// ==== rtl/fetch_stage.sv ====
// fetch front end top level: predictor, pc generator, fetch slot ring and drain

`timescale 1ns/1ps

module fetch_stage #(
	parameter int queue_depth = 4,   // fetch slots, power of two
	parameter int bp_entries  = 16   // predictor entries, power of two
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             decode_ready,
	input  logic                             ex_branch,
	input  logic [fetch_pkg::xlen-1:0]       ex_pc,
	input  logic                             ex_taken,
	input  logic [fetch_pkg::xlen-1:0]       ex_target_pc,
	input  logic                             branch_misprediction,
	input  logic [fetch_pkg::tag_width-1:0]  mem_response,
	input  logic [fetch_pkg::tag_width-1:0]  mem_tag,
	input  logic [fetch_pkg::data_width-1:0] mem_data,
	output fetch_pkg::bus_command_e          mem_command,
	output logic [fetch_pkg::xlen-1:0]       mem_addr,
	output logic                             if_valid,
	output logic [fetch_pkg::xlen-1:0]       if_pc,
	output logic [fetch_pkg::xlen-1:0]       if_npc,
	output logic [fetch_pkg::inst_width-1:0] if_inst,
	output logic                             if_predict_taken,
	output logic [fetch_pkg::xlen-1:0]       if_predict_target
);

	import fetch_pkg::*;

	localparam int idx_w = $clog2(queue_depth);

	logic [xlen-1:0]      pc;
	logic                 predict_taken;
	logic [xlen-1:0]      predict_target;
	logic                 alloc;
	logic [idx_w-1:0]     tail_index;
	logic [xlen-1:0]      alloc_pc;
	logic [tag_width-1:0] alloc_tag;
	logic                 alloc_predict_taken;
	logic [xlen-1:0]      alloc_predict_target;
	logic                 pop;

	// per-slot vectors toward the drain
	logic [queue_depth-1:0]                 slot_ready_vec;
	logic [queue_depth-1:0][xlen-1:0]       slot_pc;
	logic [queue_depth-1:0][inst_width-1:0] slot_inst;
	logic [queue_depth-1:0]                 slot_predict_taken;
	logic [queue_depth-1:0][xlen-1:0]       slot_predict_target;
	logic [queue_depth-1:0]                 release_vec;

	branch_predictor #(.bp_entries(bp_entries)) u_bp (
		.clock, .reset, .pc, .ex_branch, .ex_pc, .ex_taken, .ex_target_pc,
		.predict_taken, .predict_target
	);

	fetch_pc_gen #(.queue_depth(queue_depth)) u_pc_gen (
		.clock, .reset, .predict_taken, .predict_target, .branch_misprediction,
		.ex_target_pc, .mem_response, .pop, .pc, .mem_command, .mem_addr, .alloc,
		.tail_index, .alloc_pc, .alloc_tag, .alloc_predict_taken, .alloc_predict_target
	);

	//////////////////////////////////////////////////
	// slot ring
	//////////////////////////////////////////////////

	for (genvar i = 0; i < queue_depth; i++) begin : g_slot
		fetch_slot u_slot (
			.clock, .reset, .flush(branch_misprediction),
			.alloc(alloc && (tail_index == idx_w'(i))),  // tail slot only
			.alloc_pc, .alloc_tag, .alloc_predict_taken, .alloc_predict_target,
			.mem_tag, .mem_data, .slot_release(release_vec[i]),
			.ready(slot_ready_vec[i]), .slot_pc(slot_pc[i]), .slot_inst(slot_inst[i]),
			.slot_predict_taken(slot_predict_taken[i]),
			.slot_predict_target(slot_predict_target[i])
		);
	end

	fetch_drain #(.queue_depth(queue_depth)) u_drain (
		.clock, .reset, .flush(branch_misprediction), .decode_ready, .slot_ready_vec,
		.slot_pc, .slot_inst, .slot_predict_taken, .slot_predict_target,
		.if_valid, .if_pc, .if_npc, .if_inst, .if_predict_taken, .if_predict_target,
		.pop, .release_vec
	);

endmodule

// ==== tb.f ====
rtl/fetch_pkg.sv
rtl/branch_predictor.sv
rtl/fetch_pc_gen.sv
rtl/fetch_slot.sv
rtl/fetch_drain.sv
rtl/fetch_stage.sv
tests/imem_model.sv
tests/tb_fetch.sv

// ==== tests/imem_model.sv ====
// tagged instruction memory model: random refusals, per-tag latency, out-of-order return

`timescale 1ns/1ps

module imem_model #(
	parameter int fixed_latency = 3  // cycles used when random mode is off
) (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             random_mode,   // 0 = accept all, fixed latency
	input  fetch_pkg::bus_command_e          mem_command,
	input  logic [fetch_pkg::xlen-1:0]       mem_addr,
	output logic [fetch_pkg::tag_width-1:0]  mem_response,  // same-cycle accept tag
	output logic [fetch_pkg::tag_width-1:0]  mem_tag,       // data return tag, one cycle
	output logic [fetch_pkg::data_width-1:0] mem_data
);

	import fetch_pkg::*;

	localparam int num_tags = 1 << tag_width;  // tag 0 never handed out

	integer seed = 32'h177f_9c0c;

	logic [num_tags-1:0]  live;                 // tag outstanding
	logic [xlen-1:0]      pend_addr [num_tags];
	int                   pend_wait [num_tags]; // edges left before return
	logic [tag_width-1:0] next_tag;             // round robin 1 .. 15
	logic                 refuse_now;           // drawn one edge ahead, stable all cycle

	// memory contents, each 32-bit word a fixed scramble of its byte address
	function automatic logic [31:0] word_at(input logic [xlen-1:0] addr);
		return (addr ^ 32'h3c5a_96e1) + {addr[15:0], addr[31:16]};
	endfunction

	// a live tag is never reissued, so a stuck tag just stalls acceptance
	assign mem_response = (mem_command == bus_load && !refuse_now && !live[next_tag]) ?
		next_tag : tag_none;

	//////////////////////////////////////////////////
	// pending loads and returns
	//////////////////////////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		logic [tag_width-1:0] pick;
		logic                 found;
		int                   draw;
		if (reset) begin
			live       <= '0;
			next_tag   <= tag_width'(1);
			refuse_now <= 1'b0;
			mem_tag    <= tag_none;
			mem_data   <= '0;
		end else begin
			found = 1'b0;
			pick  = tag_none;
			// lowest due tag wins, the rest wait, which reorders returns
			for (int t = 1; t < num_tags; t++) begin
				if (!found && live[t] && pend_wait[t] <= 1) begin
					found = 1'b1;
					pick  = tag_width'(t);
				end
				if (live[t] && pend_wait[t] > 1)
					pend_wait[t] <= pend_wait[t] - 1;
			end
			if (found) begin
				mem_tag    <= pick;
				mem_data   <= {word_at(pend_addr[pick] + 32'd4), word_at(pend_addr[pick])};
				live[pick] <= 1'b0;
			end else begin
				mem_tag  <= tag_none;
				mem_data <= '0;
			end
			if (mem_response != tag_none) begin  // load accepted on this edge
				draw = $random(seed) & 32'h7fff_ffff;
				live[next_tag]      <= 1'b1;
				pend_addr[next_tag] <= mem_addr;
				pend_wait[next_tag] <= random_mode ? 1 + (draw % 6) : fixed_latency;
				next_tag <= (next_tag == tag_width'(num_tags - 1)) ?
					tag_width'(1) : next_tag + tag_width'(1);
			end
			draw = $random(seed) & 32'h7fff_ffff;
			refuse_now <= random_mode && (draw % 4 == 0);  // about one in four refused
		end
	end

endmodule

// ==== tests/tb_fetch.sv ====
// testbench for the fetch front end: clock, reset, directed tests, reference checks, watchdog

`timescale 1ns/1ps

module tb_fetch;

	import fetch_pkg::*;

	localparam int queue_depth = 4;
	localparam int bp_entries  = 16;
	localparam int clk_period  = 8;
	// cycle budgets per test, the watchdog allows twice their sum
	localparam int budget_seq   = 100;
	localparam int budget_ooo   = 300;
	localparam int budget_bp    = 250;
	localparam int budget_flush = 300;
	localparam int budget_pred  = 200;
	localparam int budget_hyst  = 200;
	localparam int watchdog_cycles = 2 * (budget_seq + budget_ooo + budget_bp +
		budget_flush + budget_pred + budget_hyst);
	localparam logic [xlen-1:0] no_branch = 32'hffff_fffc;  // never fetched in these tests

	logic                  clock;
	logic                  reset;
	logic                  decode_ready;
	logic                  ex_branch;
	logic [xlen-1:0]       ex_pc;
	logic                  ex_taken;
	logic [xlen-1:0]       ex_target_pc;
	logic                  branch_misprediction;
	logic                  random_mode;
	logic [tag_width-1:0]  mem_response;
	logic [tag_width-1:0]  mem_tag;
	logic [data_width-1:0] mem_data;
	bus_command_e          mem_command;
	logic [xlen-1:0]       mem_addr;
	logic                  if_valid;
	logic [xlen-1:0]       if_pc;
	logic [xlen-1:0]       if_npc;
	logic [inst_width-1:0] if_inst;
	logic                  if_predict_taken;
	logic [xlen-1:0]       if_predict_target;

	// transfers seen by decode, in arrival order
	logic [xlen-1:0]       got_pc   [$];
	logic [xlen-1:0]       got_npc  [$];
	logic [inst_width-1:0] got_inst [$];
	logic                  got_pt   [$];
	logic [xlen-1:0]       got_ptgt [$];

	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	fetch_stage #(.queue_depth(queue_depth), .bp_entries(bp_entries)) u_dut (
		.clock, .reset, .decode_ready, .ex_branch, .ex_pc, .ex_taken, .ex_target_pc,
		.branch_misprediction, .mem_response, .mem_tag, .mem_data, .mem_command, .mem_addr,
		.if_valid, .if_pc, .if_npc, .if_inst, .if_predict_taken, .if_predict_target
	);

	imem_model u_imem (
		.clock, .reset, .random_mode, .mem_command, .mem_addr, .mem_response, .mem_tag, .mem_data
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// inputs only move on rising edges, so the falling edge sees what the next edge takes
	always @(negedge clock) begin
		if (!reset && !branch_misprediction && if_valid && decode_ready) begin
			got_pc.push_back(if_pc);
			got_npc.push_back(if_npc);
			got_inst.push_back(if_inst);
			got_pt.push_back(if_predict_taken);
			got_ptgt.push_back(if_predict_target);
		end
	end

	// instruction at a pc, per the memory fill rule
	function automatic logic [inst_width-1:0] expected_inst(input logic [xlen-1:0] addr);
		return {addr[15:0], addr[31:16]} + (addr ^ 32'h3c5a_96e1);
	endfunction

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic clear_items();
		got_pc.delete();
		got_npc.delete();
		got_inst.delete();
		got_pt.delete();
		got_ptgt.delete();
	endtask

	task automatic apply_reset(input logic rand_on);
		@(posedge clock);
		reset                <= 1'b1;
		decode_ready         <= 1'b0;
		ex_branch            <= 1'b0;
		branch_misprediction <= 1'b0;
		random_mode          <= rand_on;
		repeat (5) @(posedge clock);
		clear_items();
		reset <= 1'b0;
	endtask

	task automatic flush_to(input logic [xlen-1:0] target);
		@(posedge clock);
		branch_misprediction <= 1'b1;
		ex_target_pc         <= target;
		@(negedge clock);
		clear_items();  // nothing is recorded in the flush cycle
		@(posedge clock);
		branch_misprediction <= 1'b0;
	endtask

	task automatic wait_items(input int n, input int max_cycles);
		int cycles;
		cycles = 0;
		while (got_pc.size() < n && cycles < max_cycles) begin
			@(negedge clock);
			cycles++;
		end
		if (got_pc.size() < n) begin
			$display("fetch stalled: %0d of %0d instructions reached decode in %0d cycles",
				got_pc.size(), n, max_cycles);
			test_errors++;
		end
	endtask

	// walk program order from start_pc, one predicted-taken branch at br_pc
	task automatic check_stream(input int n, input logic [xlen-1:0] start_pc,
			input logic [xlen-1:0] br_pc, input logic [xlen-1:0] br_target);
		logic [xlen-1:0] exp_pc;
		logic            exp_taken;
		exp_pc = start_pc;
		for (int i = 0; i < n && i < got_pc.size(); i++) begin
			exp_taken = (exp_pc == br_pc);
			if (got_pc[i] != exp_pc) begin
				$display("error %0t: item %0d pc %h, expected %h", $time, i, got_pc[i], exp_pc);
				test_errors++;
				break;  // order is lost, later items say nothing new
			end
			if (got_npc[i] != exp_pc + 32'd4) begin
				$display("error %0t: pc %h npc %h, expected %h", $time, exp_pc, got_npc[i],
					exp_pc + 32'd4);
				test_errors++;
			end
			if (got_inst[i] != expected_inst(exp_pc)) begin
				$display("error %0t: pc %h inst %h, expected %h", $time, exp_pc, got_inst[i],
					expected_inst(exp_pc));
				test_errors++;
			end
			if (got_pt[i] != exp_taken || (exp_taken && got_ptgt[i] != br_target)) begin
				$display("error %0t: pc %h prediction %b/%h, expected %b/%h", $time, exp_pc,
					got_pt[i], got_ptgt[i], exp_taken, br_target);
				test_errors++;
			end
			exp_pc = exp_taken ? br_target : exp_pc + 32'd4;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_sequential();
		apply_reset(1'b0);
		decode_ready <= 1'b1;
		wait_items(12, budget_seq);
		check_stream(12, 32'h0, no_branch, 32'h0);
		finish_test("sequential");
	endtask

	task automatic test_out_of_order();
		apply_reset(1'b1);
		decode_ready <= 1'b1;
		wait_items(40, budget_ooo);
		check_stream(40, 32'h0, no_branch, 32'h0);
		finish_test("out_of_order");
	endtask

	task automatic test_backpressure();
		apply_reset(1'b1);  // decode_ready stays low
		repeat (16) @(negedge clock);  // long enough to fill every slot
		for (int c = 0; c < 16; c++) begin
			@(negedge clock);
			if (mem_command != bus_none) begin
				$display("error %0t: load issued with a full queue", $time);
				test_errors++;
			end
			if (!if_valid || if_pc != 32'h0 || if_inst != expected_inst(32'h0)) begin
				$display("error %0t: stalled head %b/%h/%h, expected 1/0/%h", $time,
					if_valid, if_pc, if_inst, expected_inst(32'h0));
				test_errors++;
			end
		end
		@(posedge clock);
		decode_ready <= 1'b1;
		wait_items(24, budget_bp);
		check_stream(24, 32'h0, no_branch, 32'h0);
		finish_test("backpressure");
	endtask

	task automatic test_flush();
		apply_reset(1'b1);
		decode_ready <= 1'b1;
		wait_items(6, budget_flush);
		flush_to(32'h200);  // old tags still in flight come back late
		wait_items(16, budget_flush);
		check_stream(16, 32'h200, no_branch, 32'h0);
		finish_test("flush");
	endtask

	task automatic test_prediction();
		apply_reset(1'b0);
		ex_branch    <= 1'b1;  // one taken resolution trains a new entry
		ex_pc        <= 32'h40;
		ex_taken     <= 1'b1;
		ex_target_pc <= 32'h100;
		@(posedge clock);
		ex_branch    <= 1'b0;
		decode_ready <= 1'b1;
		wait_items(24, budget_pred);
		check_stream(24, 32'h0, 32'h40, 32'h100);
		finish_test("prediction");
	endtask

	// keeps the predictor state left by test_prediction
	task automatic test_hysteresis();
		@(posedge clock);
		ex_branch <= 1'b1;
		ex_pc     <= 32'h40;
		ex_taken  <= 1'b0;
		repeat (2) @(posedge clock);  // counter 2 -> 1 -> 0
		ex_branch <= 1'b0;
		flush_to(32'h30);
		wait_items(12, budget_hyst);
		check_stream(12, 32'h30, no_branch, 32'h0);
		finish_test("hysteresis");
	endtask

	//////////////////////////////////////////////////
	// run and watchdog
	//////////////////////////////////////////////////

	initial begin
		reset                = 1'b1;
		decode_ready         = 1'b0;
		ex_branch            = 1'b0;
		ex_pc                = '0;
		ex_taken             = 1'b0;
		ex_target_pc         = '0;
		branch_misprediction = 1'b0;
		random_mode          = 1'b0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_sequential();
		test_out_of_order();
		test_backpressure();
		test_flush();
		test_prediction();
		test_hysteresis();
		$display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog: tests still running after %0d cycles", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
